// ==== Makefile ====
# Verilator build and run for the field add/subtract engine

VERILATOR  ?= verilator
FLIST      ?= flist.f
TB_TOP     ?= tb_fe_add_engine
RTL_TOP    ?= fe_add_engine
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0 -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
PASS_MSG   ?= All checks passed

SOURCES := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
src/x25519_pkg.sv
src/x25519_add.sv
src/fe_dispatch.sv
src/fe_collect.sv
src/fe_add_engine.sv
test/tb_fe_add_engine.sv

// ==== src/fe_add_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module fe_add_engine (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            in_valid,
	input  logic                            op,
	input  logic [x25519_pkg::FE_WIDTH-1:0] a,
	input  logic [x25519_pkg::FE_WIDTH-1:0] b,
	output logic                            out_valid,
	output logic [x25519_pkg::FE_WIDTH-1:0] result
);
	import x25519_pkg::*;

	// ========================================
	// Internal nets
	// ========================================

	// One enable per lane, shared operands
	logic [NUM_LANES-1:0]  lane_en;
	logic [LANE_WIDTH-1:0] lane_a;
	logic [LANE_WIDTH-1:0] lane_b;

	// Per-lane results back to the collector
	logic [NUM_LANES-1:0]                 lane_valid;
	logic [NUM_LANES-1:0][LANE_WIDTH-1:0] lane_sum;

	// ========================================
	// Dispatcher
	// ========================================

	// Input register, 2p - b transform, lane pick
	fe_dispatch u_dispatch (
		.clk      (clk),
		.reset    (reset),
		.in_valid (in_valid),
		.op       (op),
		.a        (a),
		.b        (b),
		.lane_en  (lane_en),
		.lane_a   (lane_a),
		.lane_b   (lane_b)
	);

	// ========================================
	// Lanes
	// ========================================

	// Each lane only toggles on its own turn
	for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
		x25519_add u_lane (
			.clk       (clk),
			.reset     (reset),
			.en        (lane_en[k]),
			.a         (lane_a),
			.b         (lane_b),
			.out_valid (lane_valid[k]),
			.out       (lane_sum[k])
		);
	end

	// ========================================
	// Collector
	// ========================================

	// Fold above bit 255, then final reduce
	fe_collect u_collect (
		.clk        (clk),
		.reset      (reset),
		.lane_valid (lane_valid),
		.lane_sum   (lane_sum),
		.out_valid  (out_valid),
		.result     (result)
	);

endmodule

`default_nettype wire

// ==== src/fe_collect.sv ====
`timescale 1ns/1ps
`default_nettype none

module fe_collect (
	input  logic                                                       clk,
	input  logic                                                       reset,
	input  logic [x25519_pkg::NUM_LANES-1:0]                           lane_valid,
	input  logic [x25519_pkg::NUM_LANES-1:0][x25519_pkg::LANE_WIDTH-1:0] lane_sum,
	output logic                                                       out_valid,
	output logic [x25519_pkg::FE_WIDTH-1:0]                            result
);
	import x25519_pkg::*;

	// Bits at and above this one carry weight 2^255
	localparam int FOLD_BIT = FE_WIDTH - 1;

	// Width of the part above the fold point
	localparam int HIGH_BITS = LANE_WIDTH - FOLD_BIT;

	// Width of high part times 19
	localparam int PROD_BITS = HIGH_BITS + $bits(FOLD_MULT);

	// Bound on any lane sum, 4p
	localparam logic [FE_WIDTH+1:0] FE_4P = {FE_P, 2'b00};

	// ========================================
	// Stage one, select and fold
	// ========================================

	logic [LANE_WIDTH-1:0] sel_sum;
	logic [HIGH_BITS-1:0]  sel_high;
	logic [PROD_BITS-1:0]  fold_prod;
	logic [FE_WIDTH-1:0]   fold_next;
	logic                  any_valid;

	// AND-OR select, at most one lane valid
	always_comb begin
		sel_sum = '0;
		for (int k = 0; k < NUM_LANES; k++) begin
			if (lane_valid[k]) begin
				sel_sum = sel_sum | lane_sum[k];
			end
		end
	end

	assign any_valid = |lane_valid;

	// Split at bit 255
	assign sel_high = sel_sum[LANE_WIDTH-1:FOLD_BIT];

	// High part is small, so the product is tiny
	assign fold_prod = sel_high * FOLD_MULT;

	// Below 2^255 + 57, fits in 256 bits
	assign fold_next = {1'b0, sel_sum[FOLD_BIT-1:0]}
		+ {{(FE_WIDTH-PROD_BITS){1'b0}}, fold_prod};

	logic                fold_valid;
	logic [FE_WIDTH-1:0] fold_val;

	always_ff @(posedge clk) begin
		if (reset) begin
			fold_valid <= 1'b0;
		end else begin
			fold_valid <= any_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (any_valid) begin
			fold_val <= fold_next;
		end
	end

	// ========================================
	// Stage two, conditional subtract
	// ========================================

	logic [FE_WIDTH-1:0] reduced;

	// One subtraction of p is always enough after the fold
	always_comb begin
		if (fold_val >= FE_P) begin
			reduced = fold_val - FE_P;
		end else begin
			reduced = fold_val;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= fold_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (fold_valid) begin
			result <= reduced;
		end
	end

	// ========================================
	// Checks
	// ========================================

	// Round-robin dispatch keeps lane outputs apart
	a_lane_valid_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(lane_valid));

	// Dispatcher transform keeps sums under 4p
	a_sum_bound: assert property (@(posedge clk) disable iff (reset)
		any_valid |-> (sel_sum < LANE_WIDTH'(FE_4P)));

	// Output fully reduced
	a_result_canonical: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> (result < FE_P));

endmodule

`default_nettype wire

// ==== src/fe_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module fe_dispatch (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              in_valid,
	input  logic                              op,
	input  logic [x25519_pkg::FE_WIDTH-1:0]   a,
	input  logic [x25519_pkg::FE_WIDTH-1:0]   b,
	output logic [x25519_pkg::NUM_LANES-1:0]  lane_en,
	output logic [x25519_pkg::LANE_WIDTH-1:0] lane_a,
	output logic [x25519_pkg::LANE_WIDTH-1:0] lane_b
);
	import x25519_pkg::*;

	// Zero padding up to lane width
	localparam int PAD_A = LANE_WIDTH - FE_WIDTH;
	localparam int PAD_B = LANE_WIDTH - FE_WIDTH - 1;

	// Last lane index, wrap point of the pointer
	localparam logic [LANE_IDX_WIDTH-1:0] LAST_LANE = LANE_IDX_WIDTH'(NUM_LANES - 1);

	// ========================================
	// Operand transform
	// ========================================

	// 2p - b, in 0..2p since b is canonical
	logic [FE_WIDTH:0] b_neg;

	// Second operand as handed to the lane adder
	logic [FE_WIDTH:0] b_sel;

	always_comb begin
		b_neg = FE_2P - {1'b0, b};
		if (op == OP_SUB) begin
			b_sel = b_neg;
		end else begin
			b_sel = {1'b0, b};
		end
	end

	// Operand registers, shared by all lanes
	// No reset, only the strobe qualifies them
	always_ff @(posedge clk) begin
		if (in_valid) begin
			lane_a <= {{PAD_A{1'b0}}, a};
			lane_b <= {{PAD_B{1'b0}}, b_sel};
		end
	end

	// ========================================
	// Round-robin lane select
	// ========================================

	logic [LANE_IDX_WIDTH-1:0] rr_ptr;

	always_ff @(posedge clk) begin
		if (reset) begin
			lane_en <= '0;
			rr_ptr  <= '0;
		end else begin
			// One pulse per accepted op
			lane_en <= '0;
			if (in_valid) begin
				lane_en[rr_ptr] <= 1'b1;
				// Advance and wrap after the last lane
				if (rr_ptr == LAST_LANE) begin
					rr_ptr <= '0;
				end else begin
					rr_ptr <= rr_ptr + 1'b1;
				end
			end
		end
	end

	// ========================================
	// Checks
	// ========================================

	// Only canonical operands are supported
	a_canonical_in: assert property (@(posedge clk) disable iff (reset)
		in_valid |-> (a < FE_P) && (b < FE_P));

endmodule

`default_nettype wire

// ==== src/x25519_add.sv ====
`timescale 1ns/1ps
`default_nettype none

module x25519_add (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              en,
	input  logic [x25519_pkg::LANE_WIDTH-1:0] a,
	input  logic [x25519_pkg::LANE_WIDTH-1:0] b,
	output logic                              out_valid,
	output logic [x25519_pkg::LANE_WIDTH-1:0] out
);
	import x25519_pkg::*;

	localparam int HIGH_WIDTH = LANE_WIDTH - LOW_WIDTH;

	// Low half keeps its carry out in the top bit
	logic [LOW_WIDTH:0]    sum_low;
	logic [HIGH_WIDTH-1:0] sum_high;
	logic                  en_ff;

	// Valid pipe, two stages
	always_ff @(posedge clk) begin
		if (reset) begin
			en_ff     <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			en_ff     <= en;
			out_valid <= en_ff;
		end
	end

	// Stage one, independent half sums
	// Loads only when this lane is picked
	always_ff @(posedge clk) begin
		if (en) begin
			sum_low  <= {1'b0, a[LOW_WIDTH-1:0]} + {1'b0, b[LOW_WIDTH-1:0]};
			sum_high <= a[LANE_WIDTH-1:LOW_WIDTH] + b[LANE_WIDTH-1:LOW_WIDTH];
		end
	end

	// Stage two, ripple low carry into high half
	always_ff @(posedge clk) begin
		if (en_ff) begin
			out <= {sum_high + {{(HIGH_WIDTH-1){1'b0}}, sum_low[LOW_WIDTH]},
				sum_low[LOW_WIDTH-1:0]};
		end
	end

	// Split halves plus carry give the full-width sum of the operands
	a_sum_matches: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> (out == $past(a, 2) + $past(b, 2)));

endmodule

`default_nettype wire

// ==== src/x25519_pkg.sv ====
`default_nettype none

package x25519_pkg;

	// ========================================
	// Widths
	// ========================================

	// Canonical field element port, bit 255 always zero
	localparam int FE_WIDTH = 256;

	// Unreduced lane operand, headroom above 2^256
	localparam int LANE_WIDTH = 264;

	// Split point of the lane adder pipeline
	localparam int LOW_WIDTH = 128;

	// ========================================
	// Field constants
	// ========================================

	// p = 2^255 - 19
	localparam logic [FE_WIDTH-1:0] FE_P = (256'd1 << 255) - 256'd19;

	// 2p, one bit wider than p
	// Subtraction turns b into 2p - b
	localparam logic [FE_WIDTH:0] FE_2P = {FE_P, 1'b0};

	// 2^255 mod p
	localparam logic [4:0] FOLD_MULT = 5'd19;

	// ========================================
	// Lane count and op codes
	// ========================================

	// Also tested with 2 or 8
	localparam int NUM_LANES = 4;

	// Round-robin pointer, at least one bit
	localparam int LANE_IDX_WIDTH = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

	localparam logic OP_ADD = 1'b0;
	localparam logic OP_SUB = 1'b1;

endpackage

`default_nettype wire

// ==== test/fe_add_stimulus.txt ====
# name op burst a b expected, values in hex
# op 0 = add, 1 = sub; burst 1 = next op follows with no idle gap
add_small        0 0 1 2 3
add_zero         0 0 0 0 0
add_mid          0 0 12345678 87654321 99999999
add_carry128     0 0 ffffffffffffffffffffffffffffffff 1 100000000000000000000000000000000
add_carry128b    0 0 ffffffffffffffffffffffffffffffff ffffffffffffffffffffffffffffffff 1fffffffffffffffffffffffffffffffe
add_high         0 0 4000000000000000000000000000000000000000000000000000000000000000 1 4000000000000000000000000000000000000000000000000000000000000001
add_pm1_pm1      0 0 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffeb
add_to_zero      0 0 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec 1 0
add_wrap_one     0 0 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec 2 1
add_two_half     0 0 4000000000000000000000000000000000000000000000000000000000000000 4000000000000000000000000000000000000000000000000000000000000000 13
add_wrap_19      0 0 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec 14 13
add_wrap_c128    0 0 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec ffffffffffffffffffffffffffffffff fffffffffffffffffffffffffffffffe
add_pm1_pm2      0 0 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffeb 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffea
add_half_plus    0 0 4000000000000000000000000000000000000000000000000000000000000000 4000000000000000000000000000000000000000000000000000000000000001 14
add_to_p         0 0 4000000000000000000000000000000000000000000000000000000000000000 3fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed 0
sub_simple       1 0 5 3 2
sub_equal        1 0 1234 1234 0
sub_zero_one     1 0 0 1 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec
sub_zero_zero    1 0 0 0 0
sub_one_two      1 0 1 2 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec
burst_0          0 1 a 14 1e
burst_1          1 1 7 9 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffeb
burst_2          0 1 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec 5 4
burst_3          1 1 100 1 ff
burst_4          0 1 4000000000000000000000000000000000000000000000000000000000000000 4000000000000000000000000000000000000000000000000000000000000000 13
burst_5          1 1 0 13 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffda
burst_6          0 1 1 1 2
burst_7          1 0 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec 0 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec
sub_small_big    1 0 3 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec 4
sub_big_small    1 0 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec 1 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffeb
sub_pm1_pm1      1 0 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec 0
sub_zero_pm1     1 0 0 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec 1
sub_borrow128    1 0 100000000000000000000000000000000 1 ffffffffffffffffffffffffffffffff
sub_zero_half    1 0 0 4000000000000000000000000000000000000000000000000000000000000000 3fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed
sub_pm1_half     1 0 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec 4000000000000000000000000000000000000000000000000000000000000000 3fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec
sub_low          1 0 100 1 ff

// ==== test/tb_fe_add_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fe_add_engine;
	import x25519_pkg::*;

	// ========================================
	// Setup
	// ========================================

	localparam int CLK_PERIOD    = 20;
	localparam int RESET_CYCLES  = 5;
	// Strobe edge to result edge
	localparam int LATENCY       = 5;
	localparam int MAX_GAP       = 3;
	localparam int MAX_VEC       = 64;
	localparam int DRAIN_TIMEOUT = 100;
	localparam int LINE_CHARS    = 320;
	localparam int NAME_CHARS    = 24;

	logic                clk;
	logic                reset;
	logic                in_valid;
	logic                op;
	logic [FE_WIDTH-1:0] a;
	logic [FE_WIDTH-1:0] b;
	logic                out_valid;
	logic [FE_WIDTH-1:0] result;

	// Vectors from the stimulus file
	logic [8*NAME_CHARS-1:0] vec_name [MAX_VEC];
	logic                    vec_op [MAX_VEC];
	logic                    vec_burst [MAX_VEC];
	logic [FE_WIDTH-1:0]     vec_a [MAX_VEC];
	logic [FE_WIDTH-1:0]     vec_b [MAX_VEC];
	logic [FE_WIDTH-1:0]     vec_exp [MAX_VEC];
	int                      num_vec;

	// Edge time at which each strobe is presented, oldest first
	time strobe_times [$];

	int errors;
	int num_results;
	int missing;

	fe_add_engine u_fe_add_engine (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.op        (op),
		.a         (a),
		.b         (b),
		.out_valid (out_valid),
		.result    (result)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	// ========================================
	// Stimulus
	// ========================================

	// Lines that do not parse into six fields are comments
	task automatic load_vectors();
		int                      fd;
		int                      status;
		int                      fields;
		logic [8*LINE_CHARS-1:0] line;
		logic [8*NAME_CHARS-1:0] name;
		int                      op_v;
		int                      burst_v;
		logic [FE_WIDTH-1:0]     a_v;
		logic [FE_WIDTH-1:0]     b_v;
		logic [FE_WIDTH-1:0]     exp_v;
		fd = $fopen("test/fe_add_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file test/fe_add_stimulus.txt");
			errors++;
		end else begin
			while (!$feof(fd) && num_vec < MAX_VEC) begin
				line = '0;
				status = $fgets(line, fd);
				if (status > 0) begin
					fields = $sscanf(line, "%s %d %d %h %h %h",
						name, op_v, burst_v, a_v, b_v, exp_v);
					if (fields == 6) begin
						vec_name[num_vec]  = name;
						vec_op[num_vec]    = op_v[0];
						vec_burst[num_vec] = burst_v[0];
						vec_a[num_vec]     = a_v;
						vec_b[num_vec]     = b_v;
						vec_exp[num_vec]   = exp_v;
						num_vec++;
					end
				end
			end
			$fclose(fd);
		end
		if (num_vec == 0) begin
			$display("No vectors were read from the stimulus file");
			errors++;
		end
	endtask

	// Junk on the data inputs while idle
	task automatic drive_idle();
		in_valid <= 1'b0;
		op       <= 1'b0;
		a        <= {8{$urandom()}};
		b        <= {8{$urandom()}};
	endtask

	task automatic drive_all();
		int gap;
		for (int i = 0; i < num_vec; i++) begin
			@(posedge clk);
			in_valid <= 1'b1;
			op       <= vec_op[i];
			a        <= vec_a[i];
			b        <= vec_b[i];
			// Latency counts from this edge
			strobe_times.push_back($time);
			// Burst vectors run back to back
			if (vec_burst[i]) begin
				gap = 0;
			end else begin
				gap = $urandom % (MAX_GAP + 1);
			end
			repeat (gap) begin
				@(posedge clk);
				drive_idle();
			end
		end
		@(posedge clk);
		drive_idle();
	endtask

	task automatic wait_for_results();
		int waited;
		waited = 0;
		while (num_results < num_vec && waited < DRAIN_TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (num_results < num_vec) begin
			$display("Timed out with %0d of %0d results never seen",
				num_vec - num_results, num_vec);
		end
		// A few more cycles to catch stray pulses
		waited = 0;
		while (waited < LATENCY + 2) begin
			@(posedge clk);
			waited++;
		end
	endtask

	// ========================================
	// Checker
	// ========================================

	// Falling edge, outputs are settled
	always @(negedge clk) begin : check_results
		time                 due;
		logic [FE_WIDTH-1:0] expected;
		assert (!(reset && out_valid)) else begin
			$display("out_valid went high while reset was held");
			errors++;
		end
		if (out_valid && !reset) begin
			assert (strobe_times.size() > 0) else begin
				$display("out_valid pulsed with no operation in flight");
				errors++;
			end
			if (strobe_times.size() > 0) begin
				due      = strobe_times.pop_front() + LATENCY*CLK_PERIOD + CLK_PERIOD/2;
				expected = vec_exp[num_results];
				// Fixed latency from the strobe edge
				assert ($time == due) else begin
					$display("[ERROR] %0s latency: expected %0t, actual %0t",
						vec_name[num_results], due, $time);
					errors++;
				end
				assert (result == expected) else begin
					$display("[ERROR] %0s: expected %h, actual %h",
						vec_name[num_results], expected, result);
					errors++;
				end
				num_results++;
			end
		end
	end

	// ========================================
	// Main sequence
	// ========================================

	initial begin
		errors      = 0;
		num_results = 0;
		num_vec     = 0;
		missing     = 0;
		reset       = 1'b1;
		in_valid    = 1'b0;
		op          = 1'b0;
		a           = '0;
		b           = '0;
		void'($urandom(32'h6e4c));
		load_vectors();
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		drive_all();
		wait_for_results();
		missing = num_vec - num_results;
		$display("Errors: %0d, missing results: %0d", errors, missing);
		if (errors == 0 && missing == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
